//--- hw/sdrc_pkg.sv
// sdram controller shared definitions
package sdrc_pkg;

   // {cs_n, ras_n, cas_n, we_n}, all active low
   typedef logic [3:0] sdr_cmd_t;

   localparam sdr_cmd_t CMD_DESEL     = 4'b1111;
   localparam sdr_cmd_t CMD_PRECHARGE = 4'b0010;
   localparam sdr_cmd_t CMD_ACTIVATE  = 4'b0011;
   localparam sdr_cmd_t CMD_READ      = 4'b0101;
   localparam sdr_cmd_t CMD_WRITE     = 4'b0100;
   localparam sdr_cmd_t CMD_BT        = 4'b0110;   // burst terminate
   localparam sdr_cmd_t CMD_REFRESH   = 4'b0001;
   localparam sdr_cmd_t CMD_MODE      = 4'b0000;   // mode register write

   // bank controller opcodes
   typedef enum logic [1:0] {
      OP_PRE = 2'b00,
      OP_ACT = 2'b01,
      OP_RD  = 2'b10,
      OP_WR  = 2'b11
   } req_op_e;

   typedef logic [12:0] row_addr_t;    // sdram address bus
   typedef logic [1:0]  bank_t;
   typedef logic [3:0]  req_id_t;      // transfer tag
   typedef logic [7:0]  xfr_len_t;     // length in columns
   typedef logic [3:0]  delay_t;       // timing delay, clocks
   typedef logic [11:0] rfsh_timer_t;  // clocks per row refresh
   typedef logic [2:0]  rfsh_rows_t;   // rows per refresh burst

   localparam row_addr_t PRECHARGE_ALL_ADDR = 13'h0400;  // a10 set, all banks

   localparam int BURST_COL_W      = 2;   // 4-column bursts
   localparam int INIT_REFRESH_CNT = 15;  // refreshes in power-up sequence
   localparam int MODE_WAIT        = 7;   // tmrd after mode write
   localparam int MAX_CAS          = 4;

endpackage

//--- hw/sdrc_cmd_if.sv
// command request bus, one source to the arbiter
interface sdrc_cmd_if;
   logic                 req;    // held with its fields until ack
   sdrc_pkg::sdr_cmd_t   cmd;
   sdrc_pkg::bank_t      ba;
   sdrc_pkg::row_addr_t  addr;
   logic                 ack;    // same-cycle grant

   modport source (
      output req,
      output cmd,
      output ba,
      output addr,
      input  ack
   );

   modport sink (
      input  req,
      input  cmd,
      input  ba,
      input  addr,
      output ack
   );
endinterface

//--- hw/sdrc_init_refresh.sv
// sdram init and refresh sequencer
module sdrc_init_refresh (
   input  logic                   clk,
   input  logic                   reset_n,
   input  logic                   i_sdram_enable,
   input  sdrc_pkg::row_addr_t    i_mode_reg,
   input  sdrc_pkg::delay_t       i_trp_delay,
   input  sdrc_pkg::delay_t       i_trcar_delay,
   input  sdrc_pkg::rfsh_timer_t  i_rfsh_time,
   input  sdrc_pkg::rfsh_rows_t   i_rfsh_rmax,
   input  logic                   i_pre_ok,
   input  logic                   i_tras_ok,
   output logic                   o_init_done,
   sdrc_cmd_if.source             mgmt_bus
);
   typedef enum logic [2:0] {
      ST_POWERUP, ST_PRECHARGE, ST_PCHWT, ST_REFRESH,
      ST_REFWT, ST_MODE_REG, ST_MODE_WT, ST_ACTIVE
   } mgmt_st_e;

   mgmt_st_e               st;
   mgmt_st_e               nxt_st;
   sdrc_pkg::delay_t       tmr;        // wait down-timer
   sdrc_pkg::delay_t       tmr_d;
   logic [3:0]             rcnt;       // refreshes still to issue
   logic [3:0]             rcnt_d;
   sdrc_pkg::rfsh_timer_t  rfsh_tmr;   // free running row interval
   sdrc_pkg::rfsh_rows_t   rows_due;
   logic                   tmr_tc, rcnt_tc, rfsh_tc, ref_req, pchg_ok;
   logic                   ld_tmr, ld_rcnt, dec_rcnt;

   assign tmr_tc  = (tmr == '0);
   assign rcnt_tc = (rcnt == '0);
   assign rfsh_tc = (rfsh_tmr == i_rfsh_time);
   assign ref_req = (rows_due >= i_rfsh_rmax);   // enough rows owed
   assign pchg_ok = i_pre_ok & i_tras_ok;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         st          <= ST_POWERUP;
         tmr         <= '0;
         rcnt        <= '0;
         rfsh_tmr    <= '0;
         rows_due    <= '0;
         o_init_done <= 1'b0;
      end else begin
         st       <= nxt_st;
         tmr      <= ld_tmr ? tmr_d : (tmr_tc ? tmr : tmr - 1'b1);
         rcnt     <= ld_rcnt ? rcnt_d : (dec_rcnt ? rcnt - 1'b1 : rcnt);
         rfsh_tmr <= rfsh_tc ? '0 : rfsh_tmr + 1'b1;
         // rows only accrue once running
         rows_due <= (st != ST_ACTIVE) ? '0 : (rfsh_tc ? rows_due + 1'b1 : rows_due);
         o_init_done <= ((st == ST_ACTIVE) | o_init_done) & i_sdram_enable;
      end
   end

   always_comb begin
      nxt_st        = st;
      mgmt_bus.req  = 1'b1;                   // busy states block the engine
      mgmt_bus.cmd  = sdrc_pkg::CMD_DESEL;
      mgmt_bus.ba   = '0;
      mgmt_bus.addr = sdrc_pkg::PRECHARGE_ALL_ADDR;
      ld_tmr        = 1'b0;
      tmr_d         = i_trp_delay;
      ld_rcnt       = 1'b0;
      rcnt_d        = 4'(sdrc_pkg::INIT_REFRESH_CNT);
      dec_rcnt      = 1'b0;
      case (st)
         ST_POWERUP: begin
            mgmt_bus.req = 1'b0;
            ld_rcnt      = 1'b1;              // power-up refresh count
            nxt_st       = i_sdram_enable ? ST_PRECHARGE : ST_POWERUP;
         end
         ST_PRECHARGE: begin
            // precharge all only once no bank is mid-transfer
            mgmt_bus.cmd = pchg_ok ? sdrc_pkg::CMD_PRECHARGE : sdrc_pkg::CMD_DESEL;
            ld_tmr       = mgmt_bus.ack & pchg_ok;
            nxt_st       = (mgmt_bus.ack & pchg_ok) ? ST_PCHWT : ST_PRECHARGE;
         end
         ST_PCHWT:
            nxt_st = tmr_tc ? ST_REFRESH : ST_PCHWT;   // trp
         ST_REFRESH: begin
            mgmt_bus.cmd = sdrc_pkg::CMD_REFRESH;
            ld_tmr       = mgmt_bus.ack;
            tmr_d        = i_trcar_delay;
            dec_rcnt     = mgmt_bus.ack;
            nxt_st       = mgmt_bus.ack ? ST_REFWT : ST_REFRESH;
         end
         ST_REFWT: begin
            nxt_st = !tmr_tc ? ST_REFWT :
                     !rcnt_tc ? ST_REFRESH :
                     o_init_done ? ST_ACTIVE : ST_MODE_REG;  // mode write on power-up only
         end
         ST_MODE_REG: begin
            mgmt_bus.cmd  = sdrc_pkg::CMD_MODE;
            mgmt_bus.addr = i_mode_reg;
            ld_tmr        = mgmt_bus.ack;
            tmr_d         = 4'(sdrc_pkg::MODE_WAIT);
            nxt_st        = mgmt_bus.ack ? ST_MODE_WT : ST_MODE_REG;
         end
         ST_MODE_WT:
            nxt_st = tmr_tc ? ST_ACTIVE : ST_MODE_WT;
         ST_ACTIVE: begin
            mgmt_bus.req = 1'b0;
            ld_rcnt      = ref_req;
            rcnt_d       = {1'b0, i_rfsh_rmax};   // burst of rmax refreshes
            nxt_st       = !i_sdram_enable ? ST_POWERUP :
                           ref_req ? ST_PRECHARGE : ST_ACTIVE;
         end
      endcase
   end
endmodule

//--- hw/sdrc_xfr_engine.sv
// read and write transfer engine
module sdrc_xfr_engine (
   input  logic                 clk,
   input  logic                 reset_n,
   input  logic                 i_req,
   input  logic                 i_start,
   input  logic                 i_last,
   input  sdrc_pkg::req_id_t    i_id,
   input  sdrc_pkg::bank_t      i_ba,
   input  sdrc_pkg::row_addr_t  i_addr,
   input  sdrc_pkg::xfr_len_t   i_len,
   input  sdrc_pkg::req_op_e    i_op,
   input  logic [2:0]           i_cas_latency,
   input  logic                 i_init_done,
   input  logic                 i_mgmt_pending,
   output logic                 o_ack,
   output logic                 o_rdok,
   output logic                 o_wrnext,
   output logic                 o_rdstart,
   output logic                 o_rdlast,
   output logic                 o_wrstart,
   output logic                 o_wrlast,
   output logic                 o_pre_ok,
   output logic                 o_preemptible,
   output logic                 o_rd_ok_status,
   output logic                 o_wr_ok_status,
   output sdrc_pkg::req_id_t    o_id,
   sdrc_cmd_if.source           xfr_bus
);
   localparam int DLY_N = sdrc_pkg::MAX_CAS + 2;   // read-valid delay stages

   typedef enum logic [1:0] {XFR_IDLE, XFR_WRITE, XFR_READ, XFR_RDWT} xfr_st_e;

   xfr_st_e                st;
   xfr_st_e                nxt_st;
   xfr_st_e                ld_st;        // state for a newly taken transfer
   sdrc_pkg::row_addr_t    caddr;        // column last put out
   sdrc_pkg::bank_t        l_ba;
   sdrc_pkg::req_id_t      l_id;
   sdrc_pkg::xfr_len_t     l_len;
   logic                   l_last;
   logic [DLY_N-1:0][2:0]  rd_dly;       // {last, start, valid} per stage
   logic [2:0]             cas_sel;
   logic [2:0]             rd_tap;
   sdrc_pkg::sdr_cmd_t     op_cmd;
   sdrc_pkg::sdr_cmd_t     int_cmd;      // engine's own read/write/bt
   logic                   is_rd, is_wr, rw_op, pchg_hit, ld_xfr;
   logic                   l_end, bdry, last_col, pipe_mt;
   logic                   rd_next, wr_next, rd_start, rd_last;

   assign is_rd    = (i_op == sdrc_pkg::OP_RD);
   assign is_wr    = (i_op == sdrc_pkg::OP_WR);
   assign rw_op    = is_rd | is_wr;
   assign pchg_hit = (i_op == sdrc_pkg::OP_PRE) && (i_ba == l_ba);
   assign ld_xfr   = xfr_bus.ack & rw_op;
   assign ld_st    = is_rd ? XFR_READ : XFR_WRITE;
   assign l_end    = (l_len == 8'd1);
   assign bdry     = &caddr[sdrc_pkg::BURST_COL_W-1:0];   // next column opens a burst
   assign last_col = ld_xfr ? (i_len == 8'd1) : (l_len == 8'd2);

   always_comb begin
      unique case (i_op)
         sdrc_pkg::OP_PRE: op_cmd = sdrc_pkg::CMD_PRECHARGE;
         sdrc_pkg::OP_ACT: op_cmd = sdrc_pkg::CMD_ACTIVATE;
         sdrc_pkg::OP_RD:  op_cmd = sdrc_pkg::CMD_READ;
         sdrc_pkg::OP_WR:  op_cmd = sdrc_pkg::CMD_WRITE;
      endcase
   end

   // request side, independent of the grant
   always_comb begin
      xfr_bus.req = 1'b0;
      int_cmd     = sdrc_pkg::CMD_DESEL;
      case (st)
         XFR_IDLE:
            xfr_bus.req = i_req & i_init_done & ~i_mgmt_pending;
         XFR_READ, XFR_WRITE: begin
            if (l_end) begin
               int_cmd = sdrc_pkg::CMD_BT;   // close the open burst unless chained
               xfr_bus.req = i_req & ~i_mgmt_pending &
                             ((st == XFR_READ) ? (is_rd | pchg_hit) : rw_op);
            end else begin
               int_cmd = !bdry ? sdrc_pkg::CMD_DESEL :
                         (st == XFR_READ) ? sdrc_pkg::CMD_READ : sdrc_pkg::CMD_WRITE;
               xfr_bus.req = i_req & ~i_mgmt_pending & ~bdry & ~rw_op;  // other banks only
            end
         end
         XFR_RDWT:
            xfr_bus.req = i_req & ~i_mgmt_pending & (~is_wr | pipe_mt);  // no bus clash
      endcase
   end

   assign xfr_bus.cmd  = xfr_bus.req ? op_cmd : int_cmd;
   assign xfr_bus.addr = xfr_bus.req ? i_addr : caddr + 1'b1;
   assign xfr_bus.ba   = xfr_bus.req ? i_ba : l_ba;

   // grant side
   always_comb begin
      nxt_st         = st;
      rd_next        = xfr_bus.ack & is_rd;
      wr_next        = xfr_bus.ack & is_wr;
      o_rd_ok_status = ~i_mgmt_pending;
      o_wr_ok_status = ~i_mgmt_pending;
      case (st)
         XFR_IDLE:
            nxt_st = ld_xfr ? ld_st : XFR_IDLE;
         XFR_READ: begin
            o_wr_ok_status = 1'b0;
            if (!l_end) begin
               rd_next        = 1'b1;         // one column per clock
               o_rd_ok_status = 1'b0;
            end else
               nxt_st = (ld_xfr & is_rd) ? XFR_READ : XFR_RDWT;
         end
         XFR_WRITE: begin
            o_rd_ok_status = l_end & ~i_mgmt_pending;
            o_wr_ok_status = l_end & ~i_mgmt_pending;
            if (!l_end)
               wr_next = 1'b1;
            else
               nxt_st = ld_xfr ? ld_st : XFR_IDLE;
         end
         XFR_RDWT: begin
            o_wr_ok_status = pipe_mt & ~i_mgmt_pending;
            nxt_st = ld_xfr ? ld_st : (pipe_mt ? XFR_IDLE : XFR_RDWT);  // drain read data
         end
      endcase
   end

   // cas tap, clamped to the last stage
   assign cas_sel = (i_cas_latency > 3'(DLY_N - 1)) ? 3'(DLY_N - 1) : i_cas_latency;
   assign rd_tap  = rd_dly[cas_sel];

   always_comb begin
      pipe_mt = 1'b1;
      for (int i = 0; i < DLY_N; i++)
         pipe_mt &= ~(rd_dly[i][0] & (i <= int'(cas_sel)));  // tap stage counts as busy
   end

   assign rd_start = ld_xfr & is_rd & i_start;
   assign rd_last  = rd_next & last_col & (ld_xfr ? i_last : l_last);

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         st     <= XFR_IDLE;
         rd_dly <= '0;
      end else begin
         st     <= nxt_st;
         rd_dly <= {rd_dly[DLY_N-2:0], {rd_last, rd_start, rd_next}};
      end
   end

   // context of the running transfer
   always_ff @(posedge clk) begin
      if (ld_xfr) begin
         l_ba   <= i_ba;
         l_id   <= i_id;
         l_last <= i_last;
      end
      caddr <= ld_xfr ? i_addr : ((rd_next | wr_next) ? caddr + 1'b1 : caddr);
      l_len <= ld_xfr ? i_len : (l_end ? l_len : l_len - 1'b1);
   end

   assign o_ack         = xfr_bus.ack;
   assign o_id          = ld_xfr ? i_id : l_id;
   assign o_wrnext      = wr_next;
   assign o_wrstart     = ld_xfr & is_wr & i_start;
   assign o_wrlast      = wr_next & last_col & (ld_xfr ? i_last : l_last);
   assign o_rdok        = rd_tap[0];
   assign o_rdstart     = rd_tap[1];
   assign o_rdlast      = rd_tap[2];
   assign o_preemptible = (st == XFR_IDLE) || (st == XFR_RDWT);
   assign o_pre_ok      = o_preemptible || ((st == XFR_READ) && l_end);
endmodule

//--- hw/sdrc_cmd_arbiter.sv
// command arbiter and sdram pin registers
module sdrc_cmd_arbiter #(
   parameter int SDR_DW = 16,
   parameter int SDR_BW = 2
) (
   input  logic                 clk,
   input  logic                 reset_n,
   sdrc_cmd_if.sink             mgmt_bus,
   sdrc_cmd_if.sink             xfr_bus,
   input  logic                 i_preemptible,
   input  logic                 i_wr_next,
   input  logic [SDR_DW-1:0]    i_wrdt,
   input  logic [SDR_BW-1:0]    i_wren_n,
   output logic                 o_mgmt_pending,
   output logic                 o_sdr_cs_n,
   output logic                 o_sdr_ras_n,
   output logic                 o_sdr_cas_n,
   output logic                 o_sdr_we_n,
   output sdrc_pkg::bank_t      o_sdr_ba,
   output sdrc_pkg::row_addr_t  o_sdr_addr,
   output logic [SDR_BW-1:0]    o_sdr_dqm,
   output logic [SDR_BW-1:0]    o_sdr_den_n,
   output logic [SDR_DW-1:0]    o_sdr_dout
);
   sdrc_pkg::sdr_cmd_t   sel_cmd;
   sdrc_pkg::sdr_cmd_t   pin_cmd;

   // refresh/init wins only between transfers
   assign mgmt_bus.ack   = mgmt_bus.req & i_preemptible;
   assign xfr_bus.ack    = ~mgmt_bus.ack & xfr_bus.req;
   assign o_mgmt_pending = mgmt_bus.req;

   // engine's own commands go out with req low
   assign sel_cmd = mgmt_bus.ack ? mgmt_bus.cmd : xfr_bus.cmd;

   assign {o_sdr_cs_n, o_sdr_ras_n, o_sdr_cas_n, o_sdr_we_n} = pin_cmd;

   always_ff @(posedge clk) begin
      if (!reset_n) begin
         pin_cmd     <= sdrc_pkg::CMD_DESEL;
         o_sdr_dqm   <= '1;
         o_sdr_den_n <= '1;              // bus released
      end else begin
         pin_cmd     <= sel_cmd;
         o_sdr_dqm   <= i_wr_next ? i_wren_n : '0;
         o_sdr_den_n <= i_wr_next ? '0 : '1;
      end
   end

   always_ff @(posedge clk) begin
      if (!sel_cmd[3]) begin             // cs active
         o_sdr_addr <= mgmt_bus.ack ? mgmt_bus.addr : xfr_bus.addr;
         o_sdr_ba   <= mgmt_bus.ack ? mgmt_bus.ba : xfr_bus.ba;
      end
      if (i_wr_next)
         o_sdr_dout <= i_wrdt;           // hold last beat otherwise
   end
endmodule

//--- hw/sdrc_xfr_ctl.sv
// sdram transfer controller top
module sdrc_xfr_ctl #(
   parameter int SDR_DW = 16,
   parameter int SDR_BW = 2
) (
   input  logic                   clk,
   input  logic                   reset_n,
   // bank controller requests
   input  logic                   i_req,
   input  logic                   i_start,
   input  logic                   i_last,
   input  sdrc_pkg::req_id_t      i_id,
   input  sdrc_pkg::bank_t        i_ba,
   input  sdrc_pkg::row_addr_t    i_addr,
   input  sdrc_pkg::xfr_len_t     i_len,
   input  sdrc_pkg::req_op_e      i_op,
   input  logic                   i_tras_ok,
   output logic                   o_ack,
   output logic                   o_pre_ok,
   output logic                   o_rd_ok_status,
   output logic                   o_wr_ok_status,
   // application data
   output logic                   o_rdok,
   output logic                   o_wrnext,
   output logic                   o_rdstart,
   output logic                   o_rdlast,
   output logic                   o_wrstart,
   output logic                   o_wrlast,
   output sdrc_pkg::req_id_t      o_id,
   input  logic [SDR_DW-1:0]      i_wrdt,
   input  logic [SDR_BW-1:0]      i_wren_n,
   output logic [SDR_DW-1:0]      o_rddt,
   // configuration
   input  logic                   i_sdram_enable,
   input  sdrc_pkg::row_addr_t    i_mode_reg,
   input  logic [2:0]             i_cas_latency,
   input  sdrc_pkg::delay_t       i_trp_delay,
   input  sdrc_pkg::delay_t       i_trcar_delay,
   input  sdrc_pkg::rfsh_timer_t  i_rfsh_time,
   input  sdrc_pkg::rfsh_rows_t   i_rfsh_rmax,
   output logic                   o_init_done,
   // sdram pins
   output logic                   o_sdr_cs_n,
   output logic                   o_sdr_ras_n,
   output logic                   o_sdr_cas_n,
   output logic                   o_sdr_we_n,
   output sdrc_pkg::bank_t        o_sdr_ba,
   output sdrc_pkg::row_addr_t    o_sdr_addr,
   output logic [SDR_BW-1:0]      o_sdr_dqm,
   output logic [SDR_BW-1:0]      o_sdr_den_n,
   output logic [SDR_DW-1:0]      o_sdr_dout,
   input  logic [SDR_DW-1:0]      i_sdr_din
);
   logic  preemptible;
   logic  mgmt_pending;

   sdrc_cmd_if mgmt_bus ();   // refresh/init commands
   sdrc_cmd_if xfr_bus ();    // transfer commands

   sdrc_init_refresh u_init_refresh (
      .clk, .reset_n,
      .i_sdram_enable, .i_mode_reg, .i_trp_delay, .i_trcar_delay,
      .i_rfsh_time, .i_rfsh_rmax,
      .i_pre_ok   (o_pre_ok),
      .i_tras_ok,
      .o_init_done,
      .mgmt_bus   (mgmt_bus.source)
   );

   sdrc_xfr_engine u_xfr_engine (
      .clk, .reset_n,
      .i_req, .i_start, .i_last, .i_id, .i_ba, .i_addr, .i_len, .i_op,
      .i_cas_latency,
      .i_init_done    (o_init_done),
      .i_mgmt_pending (mgmt_pending),
      .o_ack, .o_rdok, .o_wrnext, .o_rdstart, .o_rdlast, .o_wrstart, .o_wrlast,
      .o_pre_ok,
      .o_preemptible  (preemptible),
      .o_rd_ok_status, .o_wr_ok_status, .o_id,
      .xfr_bus        (xfr_bus.source)
   );

   sdrc_cmd_arbiter #(
      .SDR_DW (SDR_DW),
      .SDR_BW (SDR_BW)
   ) u_cmd_arbiter (
      .clk, .reset_n,
      .mgmt_bus       (mgmt_bus.sink),
      .xfr_bus        (xfr_bus.sink),
      .i_preemptible  (preemptible),
      .i_wr_next      (o_wrnext),
      .i_wrdt, .i_wren_n,
      .o_mgmt_pending (mgmt_pending),
      .o_sdr_cs_n, .o_sdr_ras_n, .o_sdr_cas_n, .o_sdr_we_n,
      .o_sdr_ba, .o_sdr_addr, .o_sdr_dqm, .o_sdr_den_n, .o_sdr_dout
   );

   assign o_rddt = i_sdr_din;   // qualified by o_rdok
endmodule

//--- verif/tb_clock_gen.sv
// testbench clock and reset
module tb_clock_gen (
   output logic clk,
   output logic reset_n
);
   initial begin
      clk     = 1'b0;
      reset_n = 1'b0;
      repeat (8) @(posedge clk);   // 8 cycles in reset
      #10 reset_n = 1'b1;           // released off the edge like other inputs
   end

   always #50 clk = ~clk;   // period 100
endmodule

//--- verif/tb_sdrc_xfr_ctl.sv
// sdram transfer controller testbench
module tb_sdrc_xfr_ctl;
   localparam int SDR_DW  = 16;
   localparam int SDR_BW  = 2;
   localparam int N_XFR   = 24;
   localparam int MAX_CYC = N_XFR * 400 + 2000;   // cycle budget for the run

   logic                   clk, reset_n;
   logic                   i_req, i_start, i_last, i_tras_ok, i_sdram_enable;
   sdrc_pkg::req_id_t      i_id, o_id;
   sdrc_pkg::bank_t        i_ba, o_sdr_ba;
   sdrc_pkg::row_addr_t    i_addr, i_mode_reg, o_sdr_addr;
   sdrc_pkg::xfr_len_t     i_len;
   sdrc_pkg::req_op_e      i_op;
   logic [2:0]             i_cas_latency;
   sdrc_pkg::delay_t       i_trp_delay, i_trcar_delay;
   sdrc_pkg::rfsh_timer_t  i_rfsh_time;
   sdrc_pkg::rfsh_rows_t   i_rfsh_rmax;
   logic [SDR_DW-1:0]      i_wrdt, i_sdr_din, o_rddt, o_sdr_dout, exp_dout;
   logic [SDR_BW-1:0]      i_wren_n, o_sdr_dqm, o_sdr_den_n, exp_dqm;
   logic                   o_ack, o_pre_ok, o_rd_ok_status, o_wr_ok_status, o_init_done;
   logic                   o_rdok, o_wrnext, o_rdstart, o_rdlast, o_wrstart, o_wrlast;
   logic                   o_sdr_cs_n, o_sdr_ras_n, o_sdr_cas_n, o_sdr_we_n;

   // reference model state
   int                   seed, cyc = 0, errors = 0, n_done = 0, bursts = 0;
   int                   xp, x_len, rd_lo = -1, rd_hi = -2, init_idx = 0, rf_cnt, wr_cnt;
   logic                 busy = 1'b0, x_rd, init_seen = 1'b0, in_burst = 1'b0, wr_due = 1'b0;
   sdrc_pkg::row_addr_t  x_addr;    // first column of current transfer
   sdrc_pkg::bank_t      x_ba;
   sdrc_pkg::sdr_cmd_t   x_cmd;
   sdrc_pkg::req_id_t    x_id;

   tb_clock_gen u_clock_gen (.clk, .reset_n);

   sdrc_xfr_ctl #(.SDR_DW(SDR_DW), .SDR_BW(SDR_BW)) i_sdrc_xfr_ctl (.*);

   task automatic report_mismatch(input string name, input logic [63:0] exp, act);
      errors++;
      $display("CHECK FAILED %s: expected %0h, actual %0h", name, exp, act);
   endtask

   task automatic check_cmd(input string name, input sdrc_pkg::sdr_cmd_t exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_addr(input string name, input sdrc_pkg::row_addr_t exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_bank(input string name, input sdrc_pkg::bank_t exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_count(input string name, input sdrc_pkg::xfr_len_t exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_data(input string name, input logic [SDR_DW-1:0] exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_mask(input string name, input logic [SDR_BW-1:0] exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_flag(input string name, input logic exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   task automatic check_id(input string name, input sdrc_pkg::req_id_t exp, act);
      if (act !== exp)
         report_mismatch(name, exp, act);
   endtask

   // fresh write data, mask and read bus 10 after each edge
   task automatic next_cycle();
      @(posedge clk);
      #10;
      i_wrdt    = $random(seed);
      i_wren_n  = $random(seed);
      i_sdr_din = $random(seed);
   endtask

   task automatic end_run(input logic timed_out);
      if (timed_out)
         $display("ERROR: run stopped at cycle %0d before all transfers finished", cyc);
      $display("errors %0d, timeouts %0d, transfers %0d, refresh bursts %0d",
               errors, timed_out, n_done, bursts);
      if (errors == 0 && !timed_out)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   endtask

   // one model step per falling edge where outputs have settled
   task automatic watch_pins();
      sdrc_pkg::sdr_cmd_t   pcmd;
      sdrc_pkg::row_addr_t  col;
      int                   k;
      logic                 stepping;
      pcmd = {o_sdr_cs_n, o_sdr_ras_n, o_sdr_cas_n, o_sdr_we_n};
      if (o_ack) begin                       // accepted transfer reaches the pins next cycle
         if (in_burst) begin
            errors++;
            $display("ERROR: bank acknowledge during a refresh burst at cycle %0d", cyc);
         end
         busy   = 1'b1;
         xp     = cyc + 1;
         x_len  = i_len;
         x_addr = i_addr;
         x_ba   = i_ba;
         x_id   = i_id;
         x_rd   = (i_op == sdrc_pkg::OP_RD);
         x_cmd  = x_rd ? sdrc_pkg::CMD_READ : sdrc_pkg::CMD_WRITE;
         wr_cnt = 0;
         if (x_rd) begin
            rd_lo = xp + i_cas_latency;     // first column's pin cycle plus cas
            rd_hi = rd_lo + x_len - 1;
         end
      end
      k   = cyc - xp;
      col = x_addr + k;
      // columns still being stepped out
      stepping = busy && k >= 0 && k < x_len - 1;
      // precharge is safe between transfers and on a read's last column
      check_flag("precharge ok", !(stepping || (busy && !x_rd && k == x_len - 1)), o_pre_ok);
      if (stepping || in_burst) begin       // no new read or write taken here
         check_flag("read ok status", 1'b0, o_rd_ok_status);
         check_flag("write ok status", 1'b0, o_wr_ok_status);
      end
      // write data registered one cycle after the strobe
      if (wr_due) begin
         check_data("write data", exp_dout, o_sdr_dout);
         check_mask("write mask", exp_dqm, o_sdr_dqm);
      end
      check_mask("data enable", {SDR_BW{~wr_due}}, o_sdr_den_n);
      wr_due   = o_wrnext;
      exp_dout = i_wrdt;
      exp_dqm  = i_wren_n;
      if (o_wrnext && !busy) begin
         errors++;
         $display("ERROR: write strobe with no transfer in progress at cycle %0d", cyc);
      end else if (o_wrnext)
         wr_cnt++;
      check_flag("write start", busy && !x_rd && cyc == xp - 1, o_wrstart);
      check_flag("write last", busy && !x_rd && cyc == xp + x_len - 2, o_wrlast);
      // read return has one pulse per column
      check_flag("read valid", cyc >= rd_lo && cyc <= rd_hi, o_rdok);
      check_flag("read start", cyc == rd_lo, o_rdstart);
      check_flag("read last", cyc == rd_hi, o_rdlast);
      if (o_rdok)
         check_data("read data", i_sdr_din, o_rddt);
      if (o_wrstart || o_rdstart)
         check_id("transfer tag", x_id, o_id);
      // command pins
      if (!init_seen) begin
         if (pcmd != sdrc_pkg::CMD_DESEL) begin
            check_cmd("init sequence", (init_idx == 0) ? sdrc_pkg::CMD_PRECHARGE :
                      (init_idx <= sdrc_pkg::INIT_REFRESH_CNT) ? sdrc_pkg::CMD_REFRESH :
                      sdrc_pkg::CMD_MODE, pcmd);
            if (init_idx == 0)
               check_addr("init precharge", sdrc_pkg::PRECHARGE_ALL_ADDR, o_sdr_addr);
            if (init_idx == sdrc_pkg::INIT_REFRESH_CNT + 1)
               check_addr("init mode", i_mode_reg, o_sdr_addr);
            init_idx++;
         end
         if (o_init_done) begin             // done only after the mode write
            check_count("init commands", sdrc_pkg::INIT_REFRESH_CNT + 2, init_idx);
            init_seen = 1'b1;
         end
      end else if (busy && k >= 0 && k <= x_len) begin
         if (k == x_len) begin
            check_cmd("burst terminate", sdrc_pkg::CMD_BT, pcmd);
            check_count("write strobes", x_rd ? 0 : x_len, wr_cnt);
         end else if (k == 0 || col[sdrc_pkg::BURST_COL_W-1:0] == '0) begin
            check_cmd("column command", x_cmd, pcmd);   // burst boundary
            check_addr("column address", col, o_sdr_addr);
            check_bank("column bank", x_ba, o_sdr_ba);
         end else
            check_cmd("mid burst", sdrc_pkg::CMD_DESEL, pcmd);
      end else if (pcmd == sdrc_pkg::CMD_PRECHARGE && !in_burst) begin
         check_addr("refresh precharge", sdrc_pkg::PRECHARGE_ALL_ADDR, o_sdr_addr);
         in_burst = 1'b1;
         rf_cnt   = 0;
      end else if (pcmd == sdrc_pkg::CMD_REFRESH && in_burst) begin
         rf_cnt++;
         if (rf_cnt == i_rfsh_rmax) begin   // burst complete
            in_burst = 1'b0;
            bursts++;
         end
      end else
         check_cmd("idle bus", sdrc_pkg::CMD_DESEL, pcmd);
      if (busy && cyc == (x_rd ? rd_hi : xp + x_len)) begin
         busy = 1'b0;
         n_done++;
      end
   endtask

   always @(negedge clk) begin
      cyc++;
      if (cyc > MAX_CYC)
         end_run(1'b1);
      else if (reset_n)
         watch_pins();
   end

   initial begin
      seed           = 63937;
      i_req          = 1'b0;
      i_start        = 1'b1;                // every request is a whole transfer
      i_last         = 1'b1;
      i_id           = '0;
      i_ba           = '0;
      i_addr         = '0;
      i_len          = 8'd1;
      i_op           = sdrc_pkg::OP_RD;
      i_cas_latency  = 3'd2;
      i_tras_ok      = 1'b1;
      i_sdram_enable = 1'b0;
      i_mode_reg     = $random(seed);
      i_trp_delay    = 4'd2;
      i_trcar_delay  = 4'd3;
      i_rfsh_time    = 12'd60;              // short interval for many bursts
      i_rfsh_rmax    = 1 + $unsigned($random(seed)) % 3;
      i_wrdt         = '0;
      i_wren_n       = '0;
      i_sdr_din      = '0;
      @(posedge reset_n);
      next_cycle();
      i_sdram_enable = 1'b1;
      while (o_init_done !== 1'b1)
         @(negedge clk);
      for (int n = 0; n < N_XFR; n++) begin
         next_cycle();
         i_req         = 1'b1;
         i_op          = ($random(seed) & 1) ? sdrc_pkg::OP_WR : sdrc_pkg::OP_RD;
         i_addr        = $random(seed);
         i_ba          = $random(seed);
         i_len         = 1 + $unsigned($random(seed)) % 12;
         i_id          = n;
         i_cas_latency = 1 + $unsigned($random(seed)) % 3;
         @(negedge clk);
         while (!o_ack) begin               // held off by refresh
            next_cycle();
            @(negedge clk);
         end
         next_cycle();
         i_req = 1'b0;
         while (busy)
            next_cycle();
         repeat (8) next_cycle();           // read delay line drains before cas changes
      end
      repeat (10) next_cycle();
      if (bursts == 0) begin
         errors++;
         $display("ERROR: no refresh burst was seen during the run");
      end
      end_run(1'b0);
   end
endmodule

//--- src.f
hw/sdrc_pkg.sv
hw/sdrc_cmd_if.sv
hw/sdrc_init_refresh.sv
hw/sdrc_xfr_engine.sv
hw/sdrc_cmd_arbiter.sv
hw/sdrc_xfr_ctl.sv
verif/tb_clock_gen.sv
verif/tb_sdrc_xfr_ctl.sv
